// File: design/emu_io_pkg.sv
/*
 * Disk and pointer glue package
 * Widths, limits and drive codes shared by the I/O blocks
 */
package emu_io_pkg;

	// ====================
	// Sector buffer and disk interface
	// ====================
	localparam int SECTOR_ADDR_W = 9;
	localparam int BYTE_W        = 8;
	localparam int LBA_W         = 32;

	// Two floppies and one cartridge image
	localparam int NUM_SLOTS     = 3;

	// ====================
	// Mount description
	// ====================
	localparam int FILENO_W      = 3;
	localparam int FTYPE_W       = 2;

	// File numbers reported for each slot
	localparam logic [FILENO_W-1:0] SLOT_FILENO_0 = 3'd0;
	localparam logic [FILENO_W-1:0] SLOT_FILENO_1 = 3'd1;
	localparam logic [FILENO_W-1:0] SLOT_FILENO_2 = 3'd4;

	// ====================
	// Mouse to paddle
	// ====================
	localparam int MOUSE_PKT_W   = 25;
	localparam int AXIS_W        = 8;

	// Signed limits, one bit wider than the axis so sums never wrap
	localparam logic signed [AXIS_W:0] MOUSE_STEP_MAX = 9'sd10;
	localparam logic signed [AXIS_W:0] AXIS_MIN       = -9'sd128;
	localparam logic signed [AXIS_W:0] AXIS_MAX       = 9'sd127;

	// Digital joystick word, buttons land on bits 8:7
	localparam int JOY_W         = 14;
	localparam int JOY_BTN_LO    = 7;

endpackage

// File: design/sector_buffer.sv
/*
 * Sector buffer
 * 512-byte true dual-port RAM, host on port a, controller on port b
 */
module sector_buffer (
	input  logic                                 clk_sys,
	input  logic [emu_io_pkg::SECTOR_ADDR_W-1:0] a_addr_i,
	input  logic [emu_io_pkg::BYTE_W-1:0]        a_data_i,
	input  logic                                 a_wr_i,
	output logic [emu_io_pkg::BYTE_W-1:0]        a_q_o,
	input  logic [emu_io_pkg::SECTOR_ADDR_W-1:0] b_addr_i,
	input  logic [emu_io_pkg::BYTE_W-1:0]        b_data_i,
	input  logic                                 b_wr_i,
	output logic [emu_io_pkg::BYTE_W-1:0]        b_q_o
);

	logic [emu_io_pkg::BYTE_W-1:0] mem [2**emu_io_pkg::SECTOR_ADDR_W];

	// Host port returns old data on a write cycle
	always @(posedge clk_sys) begin
		if (a_wr_i) begin
			mem[a_addr_i] <= a_data_i;
		end
		a_q_o <= mem[a_addr_i];
	end

	// Controller port
	always @(posedge clk_sys) begin
		if (b_wr_i) begin
			mem[b_addr_i] <= b_data_i;
		end
		b_q_o <= mem[b_addr_i];
	end

endmodule

// File: design/disk_cmd_bridge.sv
/*
 * Disk command bridge
 * Turns controller strobes into sector buffer accesses and block requests
 */
module disk_cmd_bridge (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	input  logic                                 lba_sel_i,
	input  logic                                 block_rd_i,
	input  logic                                 block_wr_i,
	input  logic [2:0]                           drv_num_i,
	input  logic                                 io_rst_i,
	input  logic                                 data_wr_i,
	input  logic                                 data_rd_i,
	input  logic [emu_io_pkg::LBA_W-1:0]         ctl_data_i,
	input  logic [emu_io_pkg::NUM_SLOTS-1:0]     sd_ack_i,
	output logic [emu_io_pkg::SECTOR_ADDR_W-1:0] buf_addr_o,
	output logic [emu_io_pkg::BYTE_W-1:0]        buf_data_o,
	output logic                                 buf_wr_o,
	output logic [emu_io_pkg::LBA_W-1:0]         sd_lba_o,
	output logic [emu_io_pkg::NUM_SLOTS-1:0]     sd_rd_o,
	output logic [emu_io_pkg::NUM_SLOTS-1:0]     sd_wr_o,
	output logic                                 io_done_o
);

	// Strobe history
	logic wr_q1;
	logic wr_q2;
	logic rd_q;
	logic blrd_q;
	logic blwr_q;
	logic ack_q;

	logic wr_stb;
	logic rd_stb;
	logic blrd_stb;
	logic blwr_stb;
	logic ack_any;
	logic ack_fall;

	logic [1:0]                         slot_idx;
	logic [emu_io_pkg::NUM_SLOTS-1:0]   slot_req;

	// ====================
	// Edge detection
	// ====================

	// Data write goes through two stages before it acts
	assign wr_stb   = wr_q1 & ~wr_q2;
	assign rd_stb   = rd_q & ~data_rd_i;
	assign blrd_stb = block_rd_i & ~blrd_q;
	assign blwr_stb = block_wr_i & ~blwr_q;
	assign ack_any  = |sd_ack_i;
	assign ack_fall = ack_q & ~ack_any;

	// Drive 0 -> slot 0, drive 1 -> slot 1, drive 4 -> slot 2
	assign slot_idx = {drv_num_i[2], drv_num_i[0]};
	// Index 3 shifts out and requests nothing
	assign slot_req = {{(emu_io_pkg::NUM_SLOTS-1){1'b0}}, 1'b1} << slot_idx;

	// ====================
	// Control state
	// ====================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_q1      <= 1'b0;
			wr_q2      <= 1'b0;
			rd_q       <= 1'b0;
			blrd_q     <= 1'b0;
			blwr_q     <= 1'b0;
			ack_q      <= 1'b0;
			buf_wr_o   <= 1'b0;
			buf_addr_o <= '0;
			sd_rd_o    <= '0;
			sd_wr_o    <= '0;
			io_done_o  <= 1'b0;
		end else begin
			wr_q1  <= data_wr_i;
			wr_q2  <= wr_q1;
			rd_q   <= data_rd_i;
			blrd_q <= block_rd_i;
			blwr_q <= block_wr_i;
			ack_q  <= ack_any;

			buf_wr_o <= wr_stb & ~lba_sel_i;

			// Address reset wins over both advances
			if (io_rst_i) begin
				buf_addr_o <= '0;
			end else if (buf_wr_o | rd_stb) begin
				buf_addr_o <= buf_addr_o + 1'b1;
			end

			// Host acknowledge drops every pending request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end else begin
				if (blrd_stb) begin
					sd_rd_o <= sd_rd_o | slot_req;
				end
				if (blwr_stb) begin
					sd_wr_o <= sd_wr_o | slot_req;
				end
			end

			// Level, only reset brings it low again
			if (blrd_stb | blwr_stb | ack_fall) begin
				io_done_o <= 1'b1;
			end
		end
	end

	// Block address and write byte
	always_ff @(posedge clk_sys) begin
		if (wr_stb) begin
			if (lba_sel_i) begin
				sd_lba_o <= ctl_data_i;
			end else begin
				buf_data_o <= ctl_data_i[emu_io_pkg::BYTE_W-1:0];
			end
		end
	end

endmodule

// File: design/mount_tracker.sv
/*
 * Mount tracker
 * Latches the description of a newly mounted disk or cartridge image
 */
module mount_tracker (
	input  logic                                clk_sys,
	input  logic                                areset,
	input  logic [emu_io_pkg::NUM_SLOTS-1:0]    img_mounted_i,
	input  logic                                img_readonly_i,
	input  logic [63:0]                         img_size_i,
	input  logic [7:0]                          ioctl_index_i,
	output logic                                mounted_o,
	output logic [emu_io_pkg::FILENO_W-1:0]     fileno_o,
	output logic [emu_io_pkg::FTYPE_W-1:0]      filetype_o,
	output logic                                readonly_o,
	output logic [emu_io_pkg::LBA_W-1:0]        img_size_o
);

	logic mount_q;
	logic mount_stb;

	assign mount_stb = ~mount_q & (|img_mounted_i);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mount_q   <= 1'b0;
			mounted_o <= 1'b0;
		end else begin
			mount_q <= |img_mounted_i;
			// Controller sees a new mount as a change of this bit
			if (mount_stb) begin
				mounted_o <= ~mounted_o;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mount_stb) begin
			// Highest slot wins
			if (img_mounted_i[2]) begin
				fileno_o <= emu_io_pkg::SLOT_FILENO_2;
			end else if (img_mounted_i[1]) begin
				fileno_o <= emu_io_pkg::SLOT_FILENO_1;
			end else begin
				fileno_o <= emu_io_pkg::SLOT_FILENO_0;
			end
			filetype_o <= ioctl_index_i[7 -: emu_io_pkg::FTYPE_W];
			// Cartridge images are never written back
			readonly_o <= img_readonly_i | img_mounted_i[2];
			img_size_o <= img_size_i[emu_io_pkg::LBA_W-1:0];
		end
	end

endmodule

// File: design/mouse_axis_emu.sv
/*
 * Mouse axis emulation
 * Accumulates PS/2 mouse movement into saturating paddle axes
 */
module mouse_axis_emu (
	input  logic                                  clk_sys,
	input  logic                                  areset,
	input  logic [emu_io_pkg::MOUSE_PKT_W-1:0]    ps2_mouse_i,
	input  logic                                  invert_y_i,
	input  logic [15:0]                           analog_joy_i,
	input  logic [emu_io_pkg::JOY_W-1:0]          joy_i,
	input  logic                                  cpu_halt_i,
	output logic [emu_io_pkg::AXIS_W-1:0]         axis_x_o,
	output logic [emu_io_pkg::AXIS_W-1:0]         axis_y_o,
	output logic [emu_io_pkg::JOY_W-1:0]          joy_o
);

	logic emu_active;
	logic stb_q;
	logic pkt_stb;

	logic signed [emu_io_pkg::AXIS_W-1:0] acc_x;
	logic signed [emu_io_pkg::AXIS_W-1:0] acc_y;

	// One bit wider than the axis
	logic signed [emu_io_pkg::AXIS_W:0] move_x;
	logic signed [emu_io_pkg::AXIS_W:0] move_y;
	logic signed [emu_io_pkg::AXIS_W:0] step_x;
	logic signed [emu_io_pkg::AXIS_W:0] step_y;
	logic signed [emu_io_pkg::AXIS_W:0] sum_x;
	logic signed [emu_io_pkg::AXIS_W:0] sum_y;
	logic signed [emu_io_pkg::AXIS_W:0] sat_x;
	logic signed [emu_io_pkg::AXIS_W:0] sat_y;

	// Packet toggles bit 24 each time a new report arrives
	assign pkt_stb = stb_q ^ ps2_mouse_i[24];

	// Sign bits 4/5 with the 8-bit movement fields
	assign move_x = {ps2_mouse_i[4], ps2_mouse_i[15:8]};
	assign move_y = {ps2_mouse_i[5], ps2_mouse_i[23:16]};

	// ====================
	// Step and axis clamp
	// ====================
	assign step_x = (move_x > emu_io_pkg::MOUSE_STEP_MAX)  ? emu_io_pkg::MOUSE_STEP_MAX :
	                (move_x < -emu_io_pkg::MOUSE_STEP_MAX) ? -emu_io_pkg::MOUSE_STEP_MAX :
	                move_x;
	assign step_y = (move_y > emu_io_pkg::MOUSE_STEP_MAX)  ? emu_io_pkg::MOUSE_STEP_MAX :
	                (move_y < -emu_io_pkg::MOUSE_STEP_MAX) ? -emu_io_pkg::MOUSE_STEP_MAX :
	                move_y;

	assign sum_x = {acc_x[emu_io_pkg::AXIS_W-1], acc_x} + step_x;
	assign sum_y = invert_y_i ? ({acc_y[emu_io_pkg::AXIS_W-1], acc_y} - step_y) :
	                            ({acc_y[emu_io_pkg::AXIS_W-1], acc_y} + step_y);

	assign sat_x = (sum_x < emu_io_pkg::AXIS_MIN) ? emu_io_pkg::AXIS_MIN :
	               (sum_x > emu_io_pkg::AXIS_MAX) ? emu_io_pkg::AXIS_MAX : sum_x;
	assign sat_y = (sum_y < emu_io_pkg::AXIS_MIN) ? emu_io_pkg::AXIS_MIN :
	               (sum_y > emu_io_pkg::AXIS_MAX) ? emu_io_pkg::AXIS_MAX : sum_y;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q      <= 1'b0;
			emu_active <= 1'b0;
			acc_x      <= '0;
			acc_y      <= '0;
		end else begin
			stb_q <= ps2_mouse_i[24];
			// Real analog stick or a halted CPU takes the axes back
			if ((|analog_joy_i) | cpu_halt_i) begin
				emu_active <= 1'b0;
				acc_x      <= '0;
				acc_y      <= '0;
			end else if (pkt_stb) begin
				emu_active <= 1'b1;
				acc_x      <= sat_x[emu_io_pkg::AXIS_W-1:0];
				acc_y      <= sat_y[emu_io_pkg::AXIS_W-1:0];
			end
		end
	end

	// Output select between mouse and analog stick
	assign axis_x_o = emu_active ? acc_x : analog_joy_i[7:0];
	assign axis_y_o = emu_active ? acc_y : analog_joy_i[15:8];
	assign joy_o = {joy_i[emu_io_pkg::JOY_W-1:emu_io_pkg::JOY_BTN_LO+2],
	                emu_active ? ps2_mouse_i[1:0]
	                           : joy_i[emu_io_pkg::JOY_BTN_LO+1:emu_io_pkg::JOY_BTN_LO],
	                joy_i[emu_io_pkg::JOY_BTN_LO-1:0]};

endmodule

// File: design/emu_io_top.sv
/*
 * Disk and pointer glue top level
 * Connects the command bridge, sector buffer, mount tracker and mouse emulation
 */
module emu_io_top (
	input  logic                                  clk_sys,
	input  logic                                  areset,

	// Controller side
	input  logic                                  lba_sel_i,
	input  logic                                  block_rd_i,
	input  logic                                  block_wr_i,
	input  logic [2:0]                            drv_num_i,
	input  logic                                  io_rst_i,
	input  logic                                  data_wr_i,
	input  logic                                  data_rd_i,
	input  logic [emu_io_pkg::LBA_W-1:0]          ctl_data_i,
	output logic [emu_io_pkg::LBA_W-1:0]          ctl_data_o,
	output logic                                  io_done_o,
	output logic                                  mounted_o,
	output logic [emu_io_pkg::FILENO_W-1:0]       fileno_o,
	output logic [emu_io_pkg::FTYPE_W-1:0]        filetype_o,
	output logic                                  readonly_o,

	// Host side
	input  logic [emu_io_pkg::NUM_SLOTS-1:0]      sd_ack_i,
	input  logic [emu_io_pkg::SECTOR_ADDR_W-1:0]  sd_buff_addr_i,
	input  logic [emu_io_pkg::BYTE_W-1:0]         sd_buff_dout_i,
	input  logic                                  sd_buff_wr_i,
	input  logic [emu_io_pkg::NUM_SLOTS-1:0]      img_mounted_i,
	input  logic                                  img_readonly_i,
	input  logic [63:0]                           img_size_i,
	input  logic [7:0]                            ioctl_index_i,
	output logic [emu_io_pkg::LBA_W-1:0]          sd_lba_o,
	output logic [emu_io_pkg::NUM_SLOTS-1:0]      sd_rd_o,
	output logic [emu_io_pkg::NUM_SLOTS-1:0]      sd_wr_o,
	output logic [emu_io_pkg::BYTE_W-1:0]         sd_buff_din_o,

	// Pointer side
	input  logic [emu_io_pkg::MOUSE_PKT_W-1:0]    ps2_mouse_i,
	input  logic                                  invert_y_i,
	input  logic [15:0]                           analog_joy_i,
	input  logic [emu_io_pkg::JOY_W-1:0]          joy_i,
	input  logic                                  cpu_halt_i,
	output logic [emu_io_pkg::AXIS_W-1:0]         axis_x_o,
	output logic [emu_io_pkg::AXIS_W-1:0]         axis_y_o,
	output logic [emu_io_pkg::JOY_W-1:0]          joy_o
);

	logic [emu_io_pkg::SECTOR_ADDR_W-1:0] ctl_buf_addr;
	logic [emu_io_pkg::BYTE_W-1:0]        ctl_buf_data;
	logic                                 ctl_buf_wr;
	logic [emu_io_pkg::BYTE_W-1:0]        ctl_buf_q;
	logic [emu_io_pkg::LBA_W-1:0]         img_size;

	// ====================
	// Disk path
	// ====================
	disk_cmd_bridge bridge_i (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.lba_sel_i  (lba_sel_i),
		.block_rd_i (block_rd_i),
		.block_wr_i (block_wr_i),
		.drv_num_i  (drv_num_i),
		.io_rst_i   (io_rst_i),
		.data_wr_i  (data_wr_i),
		.data_rd_i  (data_rd_i),
		.ctl_data_i (ctl_data_i),
		.sd_ack_i   (sd_ack_i),
		.buf_addr_o (ctl_buf_addr),
		.buf_data_o (ctl_buf_data),
		.buf_wr_o   (ctl_buf_wr),
		.sd_lba_o   (sd_lba_o),
		.sd_rd_o    (sd_rd_o),
		.sd_wr_o    (sd_wr_o),
		.io_done_o  (io_done_o)
	);

	sector_buffer buffer_i (
		.clk_sys  (clk_sys),
		.a_addr_i (sd_buff_addr_i),
		.a_data_i (sd_buff_dout_i),
		.a_wr_i   (sd_buff_wr_i),
		.a_q_o    (sd_buff_din_o),
		.b_addr_i (ctl_buf_addr),
		.b_data_i (ctl_buf_data),
		.b_wr_i   (ctl_buf_wr),
		.b_q_o    (ctl_buf_q)
	);

	mount_tracker tracker_i (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.ioctl_index_i  (ioctl_index_i),
		.mounted_o      (mounted_o),
		.fileno_o       (fileno_o),
		.filetype_o     (filetype_o),
		.readonly_o     (readonly_o),
		.img_size_o     (img_size)
	);

	// Size on the block address path, else the buffer byte
	assign ctl_data_o = lba_sel_i ? img_size
	                              : {{(emu_io_pkg::LBA_W-emu_io_pkg::BYTE_W){1'b0}}, ctl_buf_q};

	// ====================
	// Pointer path
	// ====================
	mouse_axis_emu mouse_i (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.ps2_mouse_i  (ps2_mouse_i),
		.invert_y_i   (invert_y_i),
		.analog_joy_i (analog_joy_i),
		.joy_i        (joy_i),
		.cpu_halt_i   (cpu_halt_i),
		.axis_x_o     (axis_x_o),
		.axis_y_o     (axis_y_o),
		.joy_o        (joy_o)
	);

endmodule

// File: verif/emu_io_tb.sv
/*
 * Directed testbench for the disk and pointer glue
 * Covers the sector buffer, block requests, mounts and mouse emulation
 */
module emu_io_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int NUM_TESTS    = 5;
	localparam int CYCLE_BUDGET = 400;

	logic        clk_sys;
	logic        areset;
	logic        lba_sel_i;
	logic        block_rd_i;
	logic        block_wr_i;
	logic [2:0]  drv_num_i;
	logic        io_rst_i;
	logic        data_wr_i;
	logic        data_rd_i;
	logic [31:0] ctl_data_i;
	logic [31:0] ctl_data_o;
	logic        io_done_o;
	logic        mounted_o;
	logic [2:0]  fileno_o;
	logic [1:0]  filetype_o;
	logic        readonly_o;
	logic [2:0]  sd_ack_i;
	logic [8:0]  sd_buff_addr_i;
	logic [7:0]  sd_buff_dout_i;
	logic        sd_buff_wr_i;
	logic [2:0]  img_mounted_i;
	logic        img_readonly_i;
	logic [63:0] img_size_i;
	logic [7:0]  ioctl_index_i;
	logic [31:0] sd_lba_o;
	logic [2:0]  sd_rd_o;
	logic [2:0]  sd_wr_o;
	logic [7:0]  sd_buff_din_o;
	logic [24:0] ps2_mouse_i;
	logic        invert_y_i;
	logic [15:0] analog_joy_i;
	logic [13:0] joy_i;
	logic        cpu_halt_i;
	logic [7:0]  axis_x_o;
	logic [7:0]  axis_y_o;
	logic [13:0] joy_o;

	integer seed;
	logic   mouse_toggle;
	logic   mount_flag;
	int     model_x;
	int     model_y;

	emu_io_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Watchdog sized from the per-test cycle budget
	initial begin
		#(NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("Testbench failed");
		$fatal(1, "Simulation stopped by watchdog");
	end

	// ====================
	// Helpers
	// ====================
	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s (got %h, expected %h)",
			         $time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Strobe held three cycles, then a gap of three
	task automatic pulse_data_write(input logic [31:0] value);
		@(posedge clk_sys);
		ctl_data_i <= value;
		data_wr_i  <= 1'b1;
		repeat (3) @(posedge clk_sys);
		data_wr_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic clear_ctl_addr();
		@(posedge clk_sys);
		io_rst_i <= 1'b1;
		@(posedge clk_sys);
		io_rst_i <= 1'b0;
	endtask

	// Completion is seen as the request bits going back to zero
	task automatic wait_requests_clear(input int max_cycles);
		int n;
		n = 0;
		while (((sd_rd_o | sd_wr_o) != 3'b000) && (n < max_cycles)) begin
			@(negedge clk_sys);
			n++;
		end
		if ((sd_rd_o | sd_wr_o) != 3'b000) begin
			$display("Timeout: the acknowledge did not clear the block requests");
			$display("Testbench failed");
			$fatal(1, "Request wait timed out");
		end
	endtask

	task automatic mount_image(input int slot, input logic ro, input logic [63:0] size,
	                           input logic [7:0] index);
		@(posedge clk_sys);
		img_mounted_i  <= 3'b001 << slot;
		img_readonly_i <= ro;
		img_size_i     <= size;
		ioctl_index_i  <= index;
		@(posedge clk_sys);
		img_mounted_i <= 3'b000;
		@(negedge clk_sys);
	endtask

	function automatic int clamp_step(input int m);
		if (m > 10)
			return 10;
		if (m < -10)
			return -10;
		return m;
	endfunction

	function automatic int clamp_axis(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	// Packet fields are toggle 24, Y 23:16, X 15:8, signs 5/4 and buttons 1:0
	task automatic send_mouse_packet(input int dx, input int dy, input logic [1:0] btn,
	                                 input logic inv);
		logic [8:0] mx;
		logic [8:0] my;
		int         sx;
		int         sy;
		mx = dx[8:0];
		my = dy[8:0];
		mouse_toggle = ~mouse_toggle;
		@(posedge clk_sys);
		invert_y_i  <= inv;
		ps2_mouse_i <= {mouse_toggle, my[7:0], mx[7:0], 2'b00, my[8], mx[8], 2'b10, btn};
		@(posedge clk_sys);
		@(negedge clk_sys);
		sx = clamp_step(dx);
		sy = clamp_step(dy);
		model_x = clamp_axis(model_x + sx);
		model_y = inv ? clamp_axis(model_y - sy) : clamp_axis(model_y + sy);
		check_value(axis_x_o, model_x[7:0], "mouse X axis");
		check_value(axis_y_o, model_y[7:0], "mouse Y axis");
		check_value(joy_o, {joy_i[13:9], btn, joy_i[6:0]}, "mouse buttons on joystick");
	endtask

	// ====================
	// Tests
	// ====================
	task automatic reset_defaults();
		@(negedge clk_sys);
		check_value(sd_rd_o, 3'b000, "sd_rd_o after reset");
		check_value(sd_wr_o, 3'b000, "sd_wr_o after reset");
		check_value(io_done_o, 1'b0, "io_done_o after reset");
		check_value(mounted_o, 1'b0, "mounted_o after reset");
		check_value(axis_x_o, 8'h00, "axis_x_o after reset");
		check_value(axis_y_o, 8'h00, "axis_y_o after reset");
		check_value(joy_o, joy_i, "joystick pass-through after reset");
	endtask

	task automatic buffer_round_trip();
		logic [7:0] ctl_bytes [16];
		logic [7:0] host_bytes [8];
		for (int i = 0; i < 16; i++)
			ctl_bytes[i] = $random(seed);
		for (int i = 0; i < 8; i++)
			host_bytes[i] = $random(seed);

		// Controller writes, host reads
		clear_ctl_addr();
		for (int i = 0; i < 16; i++)
			pulse_data_write({24'h0, ctl_bytes[i]});
		for (int i = 0; i < 16; i++) begin
			@(posedge clk_sys);
			sd_buff_addr_i <= i;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value(sd_buff_din_o, ctl_bytes[i], $sformatf("host read byte %0d", i));
		end

		// Host writes, controller reads
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			sd_buff_addr_i <= i;
			sd_buff_dout_i <= host_bytes[i];
			sd_buff_wr_i   <= 1'b1;
		end
		@(posedge clk_sys);
		sd_buff_wr_i <= 1'b0;
		clear_ctl_addr();
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(ctl_data_o, {24'h0, host_bytes[0]}, "controller read byte 0");
		for (int i = 1; i < 8; i++) begin
			@(posedge clk_sys);
			data_rd_i <= 1'b1;
			@(posedge clk_sys);
			data_rd_i <= 1'b0;
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_value(ctl_data_o, {24'h0, host_bytes[i]},
			            $sformatf("controller read byte %0d", i));
		end
	endtask

	task automatic block_requests();
		@(posedge clk_sys);
		lba_sel_i <= 1'b1;
		pulse_data_write(32'h0001_2a40);
		@(negedge clk_sys);
		check_value(sd_lba_o, 32'h0001_2a40, "block address load");

		// Drive 4 is the cartridge slot on bit 2
		@(posedge clk_sys);
		drv_num_i  <= 3'd4;
		block_rd_i <= 1'b1;
		@(posedge clk_sys);
		block_rd_i <= 1'b0;
		@(negedge clk_sys);
		check_value(sd_rd_o, 3'b100, "read request on drive 4");
		check_value(sd_wr_o, 3'b000, "no write request on drive 4");
		check_value(io_done_o, 1'b1, "done level on request accept");

		@(posedge clk_sys);
		sd_ack_i <= 3'b100;
		wait_requests_clear(20);
		@(posedge clk_sys);
		sd_ack_i <= 3'b000;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(io_done_o, 1'b1, "done level after ack falls");

		@(posedge clk_sys);
		drv_num_i  <= 3'd1;
		block_wr_i <= 1'b1;
		@(posedge clk_sys);
		block_wr_i <= 1'b0;
		@(negedge clk_sys);
		check_value(sd_wr_o, 3'b010, "write request on drive 1");
		check_value(sd_rd_o, 3'b000, "no read request on drive 1");
		@(posedge clk_sys);
		sd_ack_i <= 3'b010;
		wait_requests_clear(20);
		@(posedge clk_sys);
		sd_ack_i <= 3'b000;
	endtask

	task automatic image_mount();
		logic [7:0]  index;
		logic [63:0] size;
		@(posedge clk_sys);
		lba_sel_i <= 1'b1;

		index = 8'hc1;
		size  = 64'h0000_0003_0004_5600;
		mount_image(1, 1'b0, size, index);
		mount_flag = ~mount_flag;
		check_value(fileno_o, 3'd1, "file number of slot 1");
		check_value(filetype_o, index[7:6], "file type of slot 1");
		check_value(readonly_o, 1'b0, "read-only flag of slot 1");
		check_value(ctl_data_o, size[31:0], "image size read-back of slot 1");
		check_value(mounted_o, mount_flag, "mounted marker after slot 1");

		repeat (3) @(posedge clk_sys);
		index = 8'h42;
		size  = 64'h0000_0000_0010_0000;
		mount_image(2, 1'b0, size, index);
		mount_flag = ~mount_flag;
		// Cartridge slot reports file 4 and is always read-only
		check_value(fileno_o, 3'd4, "file number of slot 2");
		check_value(filetype_o, index[7:6], "file type of slot 2");
		check_value(readonly_o, 1'b1, "read-only flag of slot 2");
		check_value(ctl_data_o, size[31:0], "image size read-back of slot 2");
		check_value(mounted_o, mount_flag, "mounted marker after slot 2");

		repeat (3) @(posedge clk_sys);
		index = 8'h80;
		size  = 64'h0000_0000_0002_ab00;
		mount_image(0, 1'b1, size, index);
		mount_flag = ~mount_flag;
		// A floppy takes its read-only flag from the host
		check_value(fileno_o, 3'd0, "file number of slot 0");
		check_value(filetype_o, index[7:6], "file type of slot 0");
		check_value(readonly_o, 1'b1, "read-only flag of slot 0");
		check_value(ctl_data_o, size[31:0], "image size read-back of slot 0");
		check_value(mounted_o, mount_flag, "mounted marker after slot 0");
	endtask

	task automatic mouse_paddles();
		model_x = 0;
		model_y = 0;
		send_mouse_packet(50, -3, 2'b01, 1'b0);
		send_mouse_packet(-7, 100, 2'b10, 1'b0);
		send_mouse_packet(4, 4, 2'b11, 1'b0);
		// Drive both axes into the clamps
		for (int i = 0; i < 15; i++)
			send_mouse_packet(20, 2, 2'b00, 1'b0);
		for (int i = 0; i < 30; i++)
			send_mouse_packet(-200, 30, 2'b01, 1'b1);

		// Analog stick takes over
		@(posedge clk_sys);
		analog_joy_i <= 16'h4c3a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(axis_x_o, 8'h3a, "analog X pass-through");
		check_value(axis_y_o, 8'h4c, "analog Y pass-through");
		check_value(joy_o, joy_i, "joystick pass-through with analog stick");
		@(posedge clk_sys);
		analog_joy_i <= 16'h0000;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(axis_x_o, 8'h00, "X axis cleared");
		check_value(axis_y_o, 8'h00, "Y axis cleared");

		// Accumulation restarts from zero
		model_x = 0;
		model_y = 0;
		send_mouse_packet(5, -5, 2'b10, 1'b0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		seed           = 56;
		mouse_toggle   = 1'b0;
		mount_flag     = 1'b0;
		clk_sys        = 1'b0;
		areset         = 1'b1;
		lba_sel_i      = 1'b0;
		block_rd_i     = 1'b0;
		block_wr_i     = 1'b0;
		drv_num_i      = 3'd0;
		io_rst_i       = 1'b0;
		data_wr_i      = 1'b0;
		data_rd_i      = 1'b0;
		ctl_data_i     = '0;
		sd_ack_i       = 3'b000;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = 3'b000;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		ioctl_index_i  = '0;
		ps2_mouse_i    = '0;
		invert_y_i     = 1'b0;
		analog_joy_i   = '0;
		joy_i          = 14'h2a5a;
		cpu_halt_i     = 1'b0;

		repeat (2) @(posedge clk_sys);
		areset <= 1'b0;

		reset_defaults();
		buffer_round_trip();
		block_requests();
		image_mount();
		mouse_paddles();

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: emu_io_top.f
design/emu_io_pkg.sv
design/sector_buffer.sv
design/disk_cmd_bridge.sv
design/mount_tracker.sv
design/mouse_axis_emu.sv
design/emu_io_top.sv
verif/emu_io_tb.sv

// File: Bender.yml
package:
  name: emu_io

sources:
  # Package first, then the RTL in dependency order
  - design/emu_io_pkg.sv
  - design/sector_buffer.sv
  - design/disk_cmd_bridge.sv
  - design/mount_tracker.sv
  - design/mouse_axis_emu.sv
  - design/emu_io_top.sv

  - target: test
    files:
      - verif/emu_io_tb.sv
